// ==== flist.f ====
+incdir+sim
rtl/issue_pkg.sv
rtl/fetch_queue.sv
rtl/instr_class.sv
rtl/issue_select.sv
rtl/dual_issue.sv
sim/dual_issue_tb.sv

// ==== rtl/dual_issue.sv ====
`timescale 1ns/1ns
`default_nettype none

module dual_issue
  import issue_pkg::*;
#(
  parameter int queue_depth = 8
) (
  input  logic   clock,
  input  logic   reset,
  input  logic   clear,
  input  fetch_t fetch,
  input  logic   issue_stall,
  output logic   fetch_stall,
  output issue_t issued,
  output logic [1:0] issue_count
);

  slot_t                          head0;
  slot_t                          head1;
  class_t                         cls0;
  class_t                         cls1;
  logic [$clog2(queue_depth):0]   count;
  logic [1:0]                     take;

  fetch_queue #(
    .queue_depth (queue_depth)
  ) queue (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .fetch       (fetch),
    .take        (take),
    .head0       (head0),
    .head1       (head1),
    .count       (count),
    .fetch_stall (fetch_stall)
  );

  instr_class class0 (
    .instr (head0.instr),
    .cls   (cls0)
  );

  instr_class class1 (
    .instr (head1.instr),
    .cls   (cls1)
  );

  issue_select #(
    .queue_depth (queue_depth)
  ) select (
    .head0       (head0),
    .head1       (head1),
    .cls0        (cls0),
    .cls1        (cls1),
    .count       (count),
    .issue_stall (issue_stall),
    .take        (take),
    .issued      (issued)
  );

  assign issue_count = take;

endmodule

`default_nettype wire

// ==== rtl/fetch_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_queue
  import issue_pkg::*;
#(
  parameter int queue_depth = 8
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             clear,
  input  fetch_t                           fetch,
  input  logic [1:0]                       take,
  output slot_t                            head0,
  output slot_t                            head1,
  output logic [$clog2(queue_depth):0]     count,
  output logic                             fetch_stall
);

  localparam int ptr_width   = $clog2(queue_depth);
  localparam int count_width = ptr_width + 1;
  localparam int threshold   = queue_depth / 2;

  slot_t                   slots [queue_depth];
  logic [ptr_width-1:0]    wr_ptr;
  logic [ptr_width-1:0]    rd_ptr;
  logic [count_width-1:0]  count_q;
  logic [count_width-1:0]  avail;
  logic [count_width-1:0]  count_next;
  logic                    stall_q;
  logic                    accept;

  assign accept = fetch.valid && !stall_q && !clear;
  assign avail  = clear ? '0 : count_q;
  assign count  = avail + (accept ? count_width'(2) : '0);
  assign count_next = count - count_width'(take);
  assign fetch_stall = stall_q;

  // Slot k from the head, with this cycle's beat already appended
  function automatic slot_t peek(input logic [count_width-1:0] k);
    logic [ptr_width-1:0] idx;
    slot_t                s;
    idx = rd_ptr + k[ptr_width-1:0];
    s = '{pc: '0, instr: nop_instr};
    if (k < avail) begin
      s = slots[idx];
    end else if (accept && k == avail) begin
      s = '{pc: fetch.pc, instr: fetch.data[31:0]};
    end else if (accept && k == avail + count_width'(1)) begin
      s = '{pc: fetch.pc + 32'd4, instr: fetch.data[63:32]};
    end
    return s;
  endfunction

  always_comb begin
    head0 = peek(count_width'(0));
    head1 = peek(count_width'(1));
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      slots[wr_ptr]                   <= '{pc: fetch.pc, instr: fetch.data[31:0]};
      slots[wr_ptr + ptr_width'(1)]   <= '{pc: fetch.pc + 32'd4, instr: fetch.data[63:32]};
    end
  end

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_q <= '0;
      stall_q <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + ptr_width'(2);
      end
      rd_ptr  <= rd_ptr + ptr_width'(take);
      count_q <= count_next;
      stall_q <= count_next > count_width'(threshold); // Registered half-full
    end
  end

  // A registered stall must leave room for a full beat
  a_no_overflow: assert property (@(posedge clock) disable iff (!reset)
    accept |-> (count_q <= count_width'(queue_depth - 2)))
    else $error("fetch_queue accepted a beat with %0d slots used", count_q);

  a_take_le_count: assert property (@(posedge clock) disable iff (!reset)
    count_width'(take) <= count)
    else $error("fetch_queue take %0d exceeds count %0d", take, count);

endmodule

`default_nettype wire

// ==== rtl/instr_class.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_class
  import issue_pkg::*;
(
  input  logic [31:0] instr,
  output class_t      cls
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic       rd_nz;
  logic       basic;
  logic       complex;
  logic       wren;
  logic       rden1;
  logic       rden2;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rd_nz  = |rd;

  always_comb begin
    basic   = 1'b0;
    complex = 1'b0;
    wren    = 1'b0;
    rden1   = 1'b0;
    rden2   = 1'b0;
    case (opcode)
      opc_lui, opc_auipc, opc_jal: begin
        complex = 1'b1;
        wren    = rd_nz;
      end
      opc_jalr, opc_load: begin
        complex = 1'b1;
        wren    = rd_nz;
        rden1   = 1'b1;
      end
      opc_branch, opc_store: begin
        complex = 1'b1;
        rden1   = 1'b1;
        rden2   = 1'b1;
      end
      opc_imm: begin
        case (funct3)
          f3_add, f3_slt, f3_sltu, f3_and, f3_or, f3_xor: basic = 1'b1;
          f3_sll: basic = (funct7 == f7_base);
          f3_srl: basic = (funct7 == f7_base) || (funct7 == f7_alt);
          default: basic = 1'b0;
        endcase
        complex = !basic; // Malformed shifts still known
        wren    = rd_nz;
        rden1   = 1'b1;
      end
      opc_reg: begin
        if (funct7 == f7_base) begin
          basic = 1'b1; // All eight functs
        end else if (funct7 == f7_alt) begin
          basic = (funct3 == f3_add) || (funct3 == f3_srl);
        end
        complex = !basic; // Includes M extension
        wren    = rd_nz;
        rden1   = 1'b1;
        rden2   = 1'b1;
      end
      opc_fence: begin
        complex = 1'b1;
      end
      opc_system: begin
        complex = 1'b1;
        case (funct3)
          3'd1, 3'd2, 3'd3: begin
            wren  = rd_nz;
            rden1 = 1'b1;
          end
          3'd5, 3'd6, 3'd7: begin
            wren = rd_nz; // Immediate CSR forms
          end
          default: begin
            wren = 1'b0;
          end
        endcase
      end
      default: begin
        basic = 1'b0; // Unknown, issues alone
      end
    endcase
  end

  assign cls = '{
    basic:   basic,
    complex: complex,
    wren:    wren,
    rden1:   rden1,
    rden2:   rden2,
    waddr:   rd,
    raddr1:  instr[19:15],
    raddr2:  instr[24:20]
  };

endmodule

`default_nettype wire

// ==== rtl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

  // RV32I major opcodes
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_reg    = 7'b0110011;
  localparam logic [6:0] opc_fence  = 7'b0001111;
  localparam logic [6:0] opc_system = 7'b1110011;

  // Integer ALU funct3 codes
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_srl  = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // sub / sra / srai

  localparam logic [31:0] nop_instr = 32'h00000013; // addi x0,x0,0

  // One fetch beat, lower word at pc, upper word at pc+4
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [63:0] data;
  } fetch_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } slot_t;

  typedef struct packed {
    logic       basic;   // Simple integer ALU op
    logic       complex; // Any other known RV32I op
    logic       wren;    // Integer write to nonzero rd
    logic       rden1;
    logic       rden2;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
  } class_t;

  typedef struct packed {
    logic [31:0] pc0;
    logic [31:0] npc0;
    logic [31:0] instr0;
    logic [31:0] pc1;
    logic [31:0] npc1;
    logic [31:0] instr1;
  } issue_t;

endpackage

`default_nettype wire

// ==== rtl/issue_select.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_select
  import issue_pkg::*;
#(
  parameter int queue_depth = 8
) (
  input  slot_t                            head0,
  input  slot_t                            head1,
  input  class_t                           cls0,
  input  class_t                           cls1,
  input  logic [$clog2(queue_depth):0]     count,
  input  logic                             issue_stall,
  output logic [1:0]                       take,
  output issue_t                           issued
);

  localparam int count_width = $clog2(queue_depth) + 1;

  logic        raw;
  logic        pair_ok;
  logic [1:0]  want;
  logic [31:0] npc0;
  logic [31:0] npc1;

  // Second slot reads what the first one writes
  assign raw = cls0.wren &&
               ((cls1.rden1 && cls1.raddr1 == cls0.waddr) ||
                (cls1.rden2 && cls1.raddr2 == cls0.waddr));

  assign pair_ok = cls1.basic && (cls0.basic || cls0.complex) && !raw;

  always_comb begin
    want = pair_ok ? 2'd2 : 2'd1;
    if (issue_stall) begin
      want = 2'd0;
    end
    take = want;
    if (count < count_width'(want)) begin
      take = count[1:0];
    end
  end

  // Compressed encodings advance by two
  assign npc0 = head0.pc + ((head0.instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
  assign npc1 = head1.pc + ((head1.instr[1:0] == 2'b11) ? 32'd4 : 32'd2);

  always_comb begin
    issued = '{
      pc0:    '0,
      npc0:   '0,
      instr0: nop_instr,
      pc1:    '0,
      npc1:   '0,
      instr1: nop_instr
    };
    if (take != 2'd0) begin
      issued.pc0    = head0.pc;
      issued.npc0   = npc0;
      issued.instr0 = head0.instr;
    end
    if (take == 2'd2) begin
      issued.pc1    = head1.pc;
      issued.npc1   = npc1;
      issued.instr1 = head1.instr;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the dual issue testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f flist.f \
  --top-module dual_issue_tb \
  -o dual_issue_sim

./obj_dir/dual_issue_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sim/pair_model.svh ====
`ifndef pair_model_svh
`define pair_model_svh

// Simple integer ALU op, safe as the second of a pair
function automatic logic model_basic(input logic [31:0] i);
  logic [2:0] f3;
  logic [6:0] f7;
  logic       r;
  f3 = i[14:12];
  f7 = i[31:25];
  r = 1'b0;
  if (i[6:0] == opc_imm) begin
    if (f3 == f3_sll) begin
      r = (f7 == f7_base);
    end else if (f3 == f3_srl) begin
      r = (f7 == f7_base) || (f7 == f7_alt);
    end else begin
      r = 1'b1; // add, slt, sltu, xor, or, and
    end
  end else if (i[6:0] == opc_reg) begin
    r = (f7 == f7_base) || (f7 == f7_alt && (f3 == f3_add || f3 == f3_srl));
  end
  return r;
endfunction

function automatic logic model_known(input logic [31:0] i);
  return i[6:0] inside {opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load,
                        opc_store, opc_imm, opc_reg, opc_fence, opc_system};
endfunction

function automatic logic model_writes(input logic [31:0] i);
  logic [6:0] op;
  logic       w;
  op = i[6:0];
  w = op inside {opc_lui, opc_auipc, opc_jal, opc_jalr, opc_load, opc_imm, opc_reg};
  if (op == opc_system && i[14:12] != 3'd0 && i[14:12] != 3'd4) begin
    w = 1'b1; // CSR forms
  end
  return w && (i[11:7] != 5'd0);
endfunction

function automatic logic model_reads(input logic [31:0] i, input logic [4:0] r);
  logic [6:0] op;
  logic       use1;
  logic       use2;
  op = i[6:0];
  use1 = op inside {opc_jalr, opc_branch, opc_load, opc_store, opc_imm, opc_reg} ||
         (op == opc_system && i[14:12] inside {3'd1, 3'd2, 3'd3});
  use2 = op inside {opc_branch, opc_store, opc_reg};
  return (use1 && i[19:15] == r) || (use2 && i[24:20] == r);
endfunction

function automatic logic [1:0] model_take(input logic [31:0] i0, input logic [31:0] i1,
                                          input int avail, input logic hold);
  int n;
  n = 1;
  if (model_basic(i1) && model_known(i0) &&
      !(model_writes(i0) && model_reads(i1, i0[11:7]))) begin
    n = 2;
  end
  if (hold) begin
    n = 0;
  end
  if (n > avail) begin
    n = avail;
  end
  return 2'(n);
endfunction

function automatic logic [31:0] model_npc(input slot_t s);
  return (s.instr[1:0] == 2'b11) ? s.pc + 32'd4 : s.pc + 32'd2;
endfunction

function automatic issue_t model_bundle(input slot_t s0, input slot_t s1, input logic [1:0] n);
  issue_t b;
  b.pc0    = '0;
  b.npc0   = '0;
  b.instr0 = nop_instr;
  b.pc1    = '0;
  b.npc1   = '0;
  b.instr1 = nop_instr;
  if (n >= 2'd1) begin
    b.pc0    = s0.pc;
    b.npc0   = model_npc(s0);
    b.instr0 = s0.instr;
  end
  if (n == 2'd2) begin
    b.pc1    = s1.pc;
    b.npc1   = model_npc(s1);
    b.instr1 = s1.instr;
  end
  return b;
endfunction

`endif

// ==== sim/dual_issue_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module dual_issue_tb
  import issue_pkg::*;
;

  localparam int queue_depth     = 8;
  localparam int clock_period    = 100;
  localparam int reset_cycles    = 3;
  localparam int directed_cycles = 120;
  localparam int random_cycles   = 400;
  localparam fetch_t idle_beat   = '{valid: 1'b0, pc: '0, data: '0};
  localparam slot_t  empty_slot  = '{pc: '0, instr: nop_instr};

  logic   clock;
  logic   reset;
  logic   clear;
  fetch_t fetch;
  logic   issue_stall;
  logic   fetch_stall;
  issue_t issued;
  logic [1:0] issue_count;

  slot_t       model_q [$];
  logic        model_stall;
  logic        last_accept;
  issue_t      exp_issued;
  logic [1:0]  exp_count;
  logic        exp_stall;
  int          errors;
  int          cycles;
  fetch_t      pend;
  logic        have_pend;
  logic [31:0] next_pc;

  `include "pair_model.svh"

  dual_issue #(
    .queue_depth (queue_depth)
  ) uut (
    .clock       (clock),
    .reset       (reset),
    .clear       (clear),
    .fetch       (fetch),
    .issue_stall (issue_stall),
    .fetch_stall (fetch_stall),
    .issued      (issued),
    .issue_count (issue_count)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  task automatic report_value(input string name, input logic [191:0] got,
                              input logic [191:0] want);
    errors++;
    $display("FAIL %s got %h expected %h at %0t", name, got, want, $time);
  endtask

  a_issued: assert property (@(posedge clock) disable iff (!reset) issued == exp_issued)
    else report_value("issued", $sampled(issued), $sampled(exp_issued));
  a_count: assert property (@(posedge clock) disable iff (!reset) issue_count == exp_count)
    else report_value("issue_count", $sampled(issue_count), $sampled(exp_count));
  a_stall: assert property (@(posedge clock) disable iff (!reset) fetch_stall == exp_stall)
    else report_value("fetch_stall", $sampled(fetch_stall), $sampled(exp_stall));

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc_reg};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'd0, rs2, rs1, f3, 5'd0, op};
  endfunction

  function automatic fetch_t make_beat(input logic [31:0] pc, input logic [31:0] lo,
                                       input logic [31:0] hi);
    return '{valid: 1'b1, pc: pc, data: {hi, lo}};
  endfunction

  // Few registers so that RAW hazards and x0 writes show up often
  function automatic logic [31:0] random_instr();
    int         kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [31:0] r;
    kind = $urandom % 12;
    rd   = 5'($urandom % 4);
    rs1  = 5'($urandom % 4);
    rs2  = 5'($urandom % 4);
    case (kind)
      0:       r = enc_r(f7_base, 3'($urandom % 8), rd, rs1, rs2);
      1:       r = enc_r(f7_alt, f3_add, rd, rs1, rs2);
      2:       r = enc_i(opc_imm, f3_add, rd, rs1, 12'h015);
      3:       r = enc_i(opc_imm, f3_srl, rd, rs1, {f7_alt, 5'd3});
      4:       r = enc_r(7'b0000001, f3_add, rd, rs1, rs2); // mul
      5:       r = enc_i(opc_load, 3'b010, rd, rs1, 12'h004);
      6:       r = enc_s(opc_store, 3'b010, rs1, rs2);
      7:       r = enc_s(opc_branch, 3'b000, rs1, rs2);
      8:       r = {20'h12345, rd, opc_lui};
      9:       r = enc_i(opc_system, 3'b001, rd, rs1, 12'h300); // csrrw
      10:      r = {7'd0, rs2, rs1, 3'd0, rd, 7'b1010011}; // FP add, now unknown
      default: r = 32'h00004501; // Compressed c.li
    endcase
    return r;
  endfunction

  // One cycle of stimulus plus the expected response for it
  task automatic run_cycle(input fetch_t beat, input logic hold, input logic flush);
    slot_t      s0;
    slot_t      s1;
    logic [1:0] n;
    @(posedge clock);
    #10;
    fetch       = beat;
    issue_stall = hold;
    clear       = flush;
    if (flush) begin
      model_q.delete();
    end
    last_accept = beat.valid && !model_stall && !flush;
    if (last_accept) begin
      model_q.push_back('{pc: beat.pc, instr: beat.data[31:0]});
      model_q.push_back('{pc: beat.pc + 32'd4, instr: beat.data[63:32]});
    end
    s0 = (model_q.size() > 0) ? model_q[0] : empty_slot;
    s1 = (model_q.size() > 1) ? model_q[1] : empty_slot;
    n = model_take(s0.instr, s1.instr, model_q.size(), hold);
    exp_count  = n;
    exp_issued = model_bundle(s0, s1, n);
    exp_stall  = model_stall;
    repeat (int'(n)) begin
      void'(model_q.pop_front());
    end
    model_stall = !flush && (model_q.size() > queue_depth / 2);
    cycles++;
  endtask

  task automatic drain();
    while (model_q.size() > 0) begin
      run_cycle(idle_beat, 1'b0, 1'b0);
    end
    run_cycle(idle_beat, 1'b0, 1'b0);
  endtask

  task automatic send_pair(input logic [31:0] pc, input logic [31:0] lo,
                           input logic [31:0] hi);
    run_cycle(make_beat(pc, lo, hi), 1'b0, 1'b0);
    drain();
  endtask

  task automatic run_directed();
    run_cycle(idle_beat, 1'b0, 1'b0); // Idle after reset
    run_cycle(idle_beat, 1'b0, 1'b0);
    send_pair(32'h100, enc_i(opc_imm, f3_add, 5'd1, 5'd0, 12'd5),
              enc_r(f7_base, f3_add, 5'd2, 5'd3, 5'd4));
    send_pair(32'h108, enc_i(opc_imm, f3_add, 5'd5, 5'd0, 12'd1),
              enc_r(f7_base, f3_add, 5'd6, 5'd5, 5'd5)); // RAW, splits
    send_pair(32'h110, enc_i(opc_imm, f3_add, 5'd0, 5'd1, 12'd1),
              enc_r(f7_base, f3_add, 5'd7, 5'd0, 5'd0)); // x0 write
    send_pair(32'h118, enc_r(f7_base, f3_add, 5'd1, 5'd2, 5'd3),
              enc_i(opc_load, 3'b010, 5'd4, 5'd5, 12'd0));
    send_pair(32'h120, enc_r(f7_base, f3_add, 5'd1, 5'd2, 5'd3), 32'h00208053);
    send_pair(32'h128, enc_s(opc_branch, 3'b000, 5'd1, 5'd2),
              enc_i(opc_imm, f3_add, 5'd1, 5'd1, 12'd1));
    send_pair(32'h130, enc_s(opc_store, 3'b010, 5'd1, 5'd2),
              enc_i(opc_imm, f3_xor, 5'd2, 5'd2, 12'd3));
    send_pair(32'h138, 32'h00004501, enc_r(f7_alt, f3_srl, 5'd3, 5'd1, 5'd2));
    for (int k = 0; k < 6; k++) begin
      run_cycle(make_beat(32'h400 + 32'(8 * k), random_instr(), random_instr()), 1'b1, 1'b0);
    end
    drain();
    for (int k = 0; k < 3; k++) begin
      run_cycle(make_beat(32'h500 + 32'(8 * k), random_instr(), random_instr()), 1'b1, 1'b0);
    end
    run_cycle(idle_beat, 1'b1, 1'b1); // Flush with a full queue
    repeat (3) run_cycle(idle_beat, 1'b0, 1'b0);
    send_pair(32'h600, enc_i(opc_imm, f3_or, 5'd1, 5'd2, 12'd7),
              enc_r(f7_base, f3_and, 5'd3, 5'd4, 5'd5));
  endtask

  initial begin
    reset       = 1'b0;
    clear       = 1'b0;
    fetch       = idle_beat;
    issue_stall = 1'b0;
    model_stall = 1'b0;
    last_accept = 1'b0;
    exp_issued  = model_bundle(empty_slot, empty_slot, 2'd0);
    exp_count   = 2'd0;
    exp_stall   = 1'b0;
    errors      = 0;
    cycles      = 0;
    have_pend   = 1'b0;
    pend        = idle_beat;
    next_pc     = 32'h1000;
    void'($urandom(51381));
    repeat (reset_cycles) @(posedge clock);
    #10;
    reset = 1'b1;
    run_directed();
    for (int c = 0; c < random_cycles; c++) begin
      if (!have_pend && ($urandom % 4 != 0)) begin
        pend      = make_beat(next_pc, random_instr(), random_instr());
        next_pc   = next_pc + 32'd8;
        have_pend = 1'b1;
      end
      run_cycle(have_pend ? pend : idle_beat, ($urandom % 4 == 0), ($urandom % 64 == 0));
      if (last_accept) begin
        have_pend = 1'b0; // Dropped beats are resent
      end
    end
    drain();
    @(posedge clock);
    #1;
    $display("cycles %0d errors %0d", cycles, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #((reset_cycles + directed_cycles + random_cycles + 100) * clock_period);
    $display("Timeout, the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
